// ==== odt_config.svh ====
`ifndef ODT_CONFIG_SVH
`define ODT_CONFIG_SVH

// memory interface geometry
`define ODT_MEM_IF_CHIP         4       // chip selects, one-hot from the arbiter
`define ODT_MEM_IF_ODT_WIDTH    4       // odt pins driven towards the dimms

// afi data width ratio
// 2 -> full rate, 4 -> half rate, 8 -> quarter rate
// only half rate is built here, two memory clocks per ctl_clk
`define ODT_DWIDTH_RATIO        4

// 0 ties afi_odt low whatever the csr holds
`define ODT_ENABLED             1

// csr byte addresses on the axi4-lite port
`define ODT_REG_CTRL            4'h0    // mem type, output_regd
`define ODT_REG_TIMING          4'h4    // tcl, cas_wr_lat, add_lat, burst length
`define ODT_REG_WMAP            4'h8    // write odt map, one nibble per chip
`define ODT_REG_RMAP            4'hC    // read odt map, same layout

`endif

// ==== odt_pkg.sv ====
`default_nettype none

`include "odt_config.svh"

package odt_pkg;

    localparam int ODT_PHASES = `ODT_DWIDTH_RATIO / 2;                   // mem clocks per ctl_clk
    localparam int ODT_MAP_W  = `ODT_MEM_IF_CHIP * `ODT_MEM_IF_ODT_WIDTH;
    // future slots kept per pin, covers start 20 plus a 17 slot window
    localparam int ODT_SLOTS  = 40;

    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,    // reset value, odt off
        MEM_DDR2 = 3'd1,
        MEM_DDR3 = 3'd2
    } mem_type_e;

    // arbiter command, single cycle pulse
    typedef struct packed {
        logic                         do_read;
        logic                         do_write;
        logic                         burst_chop;   // ddr3 only
        logic [`ODT_MEM_IF_CHIP-1:0]  to_chip;      // one-hot, highest bit wins
    } bg_cmd_t;

    typedef struct packed {
        mem_type_e              mem_type;
        logic [3:0]             tcl;
        logic [3:0]             cas_wr_lat;
        logic [2:0]             add_lat;
        logic [4:0]             burst_length;
        logic                   output_regd;    // one more cycle on afi_odt
        logic [ODT_MAP_W-1:0]   write_odt_chip; // nibble per chip, bit per pin
        logic [ODT_MAP_W-1:0]   read_odt_chip;
    } odt_cfg_t;

    // master to slave
    typedef struct packed {
        logic [3:0]   awaddr;
        logic         awvalid;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
        logic         wvalid;
        logic         bready;
        logic [3:0]   araddr;
        logic         arvalid;
        logic         rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic         awready;
        logic         wready;
        logic [1:0]   bresp;
        logic         bvalid;
        logic         arready;
        logic [31:0]  rdata;
        logic [1:0]   rresp;
        logic         rvalid;
    } axil_rsp_t;

    // phase h in the upper nibble, phase l in the lower
    typedef struct packed {
        logic [`ODT_MEM_IF_ODT_WIDTH-1:0] h;
        logic [`ODT_MEM_IF_ODT_WIDTH-1:0] l;
    } odt_phases_t;

    // run of len ones starting at slot start
    function automatic logic [ODT_SLOTS-1:0] odt_window(input logic [5:0] start,
                                                        input logic [5:0] len);
        logic [ODT_SLOTS-1:0] ones;
        ones = '1;
        return (ones >> (ODT_SLOTS - len)) << start;
    endfunction

endpackage

`default_nettype wire

// ==== odt_csr.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "odt_config.svh"

module odt_csr
    import odt_pkg::*;
(
    input  logic      ctl_clk,
    input  logic      rst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output odt_cfg_t  cfg
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] ctrl_q;
    logic [31:0] timing_q;
    logic [31:0] wmap_q;
    logic [31:0] rmap_q;

    logic        wr_go;     // aw and w accepted together this cycle
    logic        rd_go;     // ar accepted this cycle
    logic        wr_hit;
    logic        rd_hit;
    logic [31:0] rd_mux;

    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [1:0]  rresp_q;
    logic [31:0] rdata_q;

    // byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

    assign wr_go = axil_req.awvalid & axil_req.wvalid & ~bvalid_q; // one write in flight
    assign rd_go = axil_req.arvalid & ~rvalid_q;

    // address decode, unmapped reads return zero
    always_comb
    begin
        case (axil_req.awaddr)
            `ODT_REG_CTRL, `ODT_REG_TIMING, `ODT_REG_WMAP, `ODT_REG_RMAP: wr_hit = 1'b1;
            default:                                                      wr_hit = 1'b0;
        endcase
        rd_hit = 1'b1;
        case (axil_req.araddr)
            `ODT_REG_CTRL:   rd_mux = ctrl_q;
            `ODT_REG_TIMING: rd_mux = timing_q;
            `ODT_REG_WMAP:   rd_mux = wmap_q;
            `ODT_REG_RMAP:   rd_mux = rmap_q;
            default:
            begin
                rd_mux = '0;
                rd_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge ctl_clk)
    begin
        if (!rst_n)
        begin
            ctrl_q   <= '0;
            timing_q <= '0;
            wmap_q   <= '0;
            rmap_q   <= '0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            if (wr_go)
            begin
                case (axil_req.awaddr)
                    `ODT_REG_CTRL:   ctrl_q   <= merge_strb(ctrl_q, axil_req.wdata, axil_req.wstrb);
                    `ODT_REG_TIMING: timing_q <= merge_strb(timing_q, axil_req.wdata, axil_req.wstrb);
                    `ODT_REG_WMAP:   wmap_q   <= merge_strb(wmap_q, axil_req.wdata, axil_req.wstrb);
                    `ODT_REG_RMAP:   rmap_q   <= merge_strb(rmap_q, axil_req.wdata, axil_req.wstrb);
                    default:         ctrl_q   <= ctrl_q;    // dropped, slverr below
                endcase
                bvalid_q <= 1'b1;
            end
            else if (axil_req.bready)
                bvalid_q <= 1'b0;
            if (rd_go)
                rvalid_q <= 1'b1;
            else if (axil_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    // response payload, only looked at while valid
    always_ff @(posedge ctl_clk)
    begin
        if (wr_go)
            bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        if (rd_go)
        begin
            rdata_q <= rd_mux;
            rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb
    begin
        axil_rsp.awready = wr_go;       // aw and w ready in the same cycle
        axil_rsp.wready  = wr_go;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = ~rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

    // field extraction into the config struct
    always_comb
    begin
        cfg.mem_type       = mem_type_e'(ctrl_q[2:0]);
        cfg.output_regd    = ctrl_q[4];
        cfg.tcl            = timing_q[3:0];
        cfg.cas_wr_lat     = timing_q[7:4];
        cfg.add_lat        = timing_q[10:8];
        cfg.burst_length   = timing_q[20:16];
        cfg.write_odt_chip = wmap_q[ODT_MAP_W-1:0];
        cfg.read_odt_chip  = rmap_q[ODT_MAP_W-1:0];
    end

endmodule

`default_nettype wire

// ==== odt_ddr2_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module odt_ddr2_gen
    import odt_pkg::*;
(
    input  logic                  ctl_clk,
    input  logic                  rst_n,
    input  odt_cfg_t              cfg,
    input  logic                  do_write,     // already gated by the pin map
    input  logic                  do_read,
    output logic [ODT_PHASES-1:0] odt           // bit 0 phase l, bit 1 phase h
);

    // ddr2 odt opens at the same point for reads and writes
    logic [5:0]            start_slot;
    logic [5:0]            win_len;
    logic [ODT_SLOTS-1:0]  win_mask;

    // bit 0 is the slot shown next, phase l of the coming cycle
    logic [ODT_SLOTS-1:0]  slot_q;
    logic [ODT_PHASES-1:0] odt_q;       // extra stage for output_regd

    // tcl + al - 2 memory clocks after the command
    assign start_slot = {2'b00, cfg.tcl} + {3'b000, cfg.add_lat} - 6'd2;

    // bl/2 data clocks plus one clock of margin either side
    assign win_len = {2'b00, cfg.burst_length[4:1]} + 6'd2;

    // no burst chop on ddr2, reads and writes share one window
    assign win_mask = (do_write | do_read) ? odt_window(start_slot, win_len) : '0;

    // retire two slots per clock, new windows OR over what is in flight
    always_ff @(posedge ctl_clk)
    begin
        if (!rst_n)
        begin
            slot_q <= '0;
            odt_q  <= '0;
        end
        else
        begin
            slot_q <= (slot_q >> ODT_PHASES) | win_mask;
            odt_q  <= slot_q[ODT_PHASES-1:0];
        end
    end

    // output_regd picks the late copy, one ctl_clk behind
    assign odt = cfg.output_regd ? odt_q : slot_q[ODT_PHASES-1:0];

endmodule

`default_nettype wire

// ==== odt_ddr3_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module odt_ddr3_gen
    import odt_pkg::*;
(
    input  logic                  ctl_clk,
    input  logic                  rst_n,
    input  odt_cfg_t              cfg,
    input  logic                  do_write,     // already gated by the pin map
    input  logic                  do_read,
    input  logic                  burst_chop,   // bc4 on the current command
    output logic [ODT_PHASES-1:0] odt           // bit 0 phase l, bit 1 phase h
);

    logic [5:0]            wr_start;
    logic [5:0]            rd_start;
    logic [5:0]            win_len;
    logic [ODT_SLOTS-1:0]  wr_mask;
    logic [ODT_SLOTS-1:0]  rd_mask;

    // bit 0 is the slot shown next, phase l of the coming cycle
    logic [ODT_SLOTS-1:0]  slot_q;
    logic [ODT_PHASES-1:0] odt_q;

    // writes follow cwl and reads follow cl, additive latency is not used here
    assign wr_start = {2'b00, cfg.cas_wr_lat} - 6'd2;
    assign rd_start = {2'b00, cfg.tcl} - 6'd2;

    // bc4 keeps odt up for 4 slots only
    always_comb
    begin
        if (burst_chop)
            win_len = 6'd4;
        else
            win_len = {2'b00, cfg.burst_length[4:1]} + 6'd2;
    end

    assign wr_mask = do_write ? odt_window(wr_start, win_len) : '0;
    assign rd_mask = do_read  ? odt_window(rd_start, win_len) : '0;

    // same slot pipe as ddr2, two windows may land in one cycle
    always_ff @(posedge ctl_clk)
    begin
        if (!rst_n)
        begin
            slot_q <= '0;
            odt_q  <= '0;
        end
        else
        begin
            slot_q <= (slot_q >> ODT_PHASES) | wr_mask | rd_mask;
            odt_q  <= slot_q[ODT_PHASES-1:0];   // late copy
        end
    end

    // output_regd shifts every window one ctl_clk later
    assign odt = cfg.output_regd ? odt_q : slot_q[ODT_PHASES-1:0];

endmodule

`default_nettype wire

// ==== odt_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "odt_config.svh"

module odt_gen
    import odt_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        rst_n,
    input  odt_cfg_t    cfg,
    input  bg_cmd_t     bg_cmd,
    output odt_phases_t afi_odt
);

    localparam int NCHIP = `ODT_MEM_IF_CHIP;
    localparam int NPIN  = `ODT_MEM_IF_ODT_WIDTH;

    logic [NPIN-1:0]       sel_wr_map;      // pins to terminate for this write
    logic [NPIN-1:0]       sel_rd_map;
    logic [NPIN-1:0]       pin_wr;
    logic [NPIN-1:0]       pin_rd;
    logic [ODT_PHASES-1:0] ddr2_odt [NPIN];
    logic [ODT_PHASES-1:0] ddr3_odt [NPIN];
    logic [NPIN-1:0]       odt_l;
    logic [NPIN-1:0]       odt_h;

    // walk up the chips so the highest set bit of to_chip wins
    always_comb
    begin
        sel_wr_map = '0;    // no chip addressed, no pin asserts
        sel_rd_map = '0;
        for (int c = 0; c < NCHIP; c++)
        begin
            if (bg_cmd.to_chip[c])
            begin
                sel_wr_map = cfg.write_odt_chip[c*NPIN +: NPIN];
                sel_rd_map = cfg.read_odt_chip[c*NPIN +: NPIN];
            end
        end
    end

    assign pin_wr = sel_wr_map & {NPIN{bg_cmd.do_write}};
    assign pin_rd = sel_rd_map & {NPIN{bg_cmd.do_read}};

    // both generators run per pin, mem_type picks one afterwards
    for (genvar p = 0; p < NPIN; p++)
    begin : g_pin
        odt_ddr2_gen odt_ddr2_gen_i (
            .ctl_clk    (ctl_clk),
            .rst_n      (rst_n),
            .cfg        (cfg),
            .do_write   (pin_wr[p]),
            .do_read    (pin_rd[p]),
            .odt        (ddr2_odt[p])
        );

        odt_ddr3_gen odt_ddr3_gen_i (
            .ctl_clk    (ctl_clk),
            .rst_n      (rst_n),
            .cfg        (cfg),
            .do_write   (pin_wr[p]),
            .do_read    (pin_rd[p]),
            .burst_chop (bg_cmd.burst_chop),
            .odt        (ddr3_odt[p])
        );
    end

    // type select and split into phases, anything else than ddr2/ddr3 is off
    always_comb
    begin
        for (int p = 0; p < NPIN; p++)
        begin
            case (cfg.mem_type)
                MEM_DDR2:
                begin
                    odt_l[p] = ddr2_odt[p][0];
                    odt_h[p] = ddr2_odt[p][1];
                end
                MEM_DDR3:
                begin
                    odt_l[p] = ddr3_odt[p][0];
                    odt_h[p] = ddr3_odt[p][1];
                end
                default:
                begin
                    odt_l[p] = 1'b0;
                    odt_h[p] = 1'b0;
                end
            endcase
        end
    end

    // half rate afi packing, h above l
    if (`ODT_ENABLED == 1)
    begin : g_odt_on
        assign afi_odt = '{h: odt_h, l: odt_l};
    end
    else
    begin : g_odt_off
        assign afi_odt = '0;
    end

endmodule

`default_nettype wire

// ==== odt_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module odt_subsys_top
    import odt_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        rst_n,
    input  axil_req_t   axil_req,   // csr access from software
    output axil_rsp_t   axil_rsp,
    input  bg_cmd_t     bg_cmd,     // arbiter command pulses
    output odt_phases_t afi_odt     // towards the phy
);

    odt_cfg_t cfg;      // static while commands are in flight

    // register block
    odt_csr odt_csr_i (
        .ctl_clk    (ctl_clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .cfg        (cfg)
    );

    // odt window generation
    odt_gen odt_gen_i (
        .ctl_clk    (ctl_clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .bg_cmd     (bg_cmd),
        .afi_odt    (afi_odt)
    );

endmodule

`default_nettype wire

// ==== tb_odt_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "odt_config.svh"

module tb_odt_subsys
    import odt_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int DRV_DLY    = 2;      // inputs change this long after the rising edge
    localparam int N_TESTS    = 5;
    localparam int TL_LEN     = 256;    // cycles covered by one expected timeline
    localparam int FLUSH      = 24;     // idle cycles so every window drains
    localparam int POLL_MAX   = 50;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        ctl_clk;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    bg_cmd_t     bg_cmd;
    odt_phases_t afi_odt;

    integer      seed;
    int          errors;
    int          checks;
    logic [31:0] ctrl_r;                // copies of what software wrote
    logic [31:0] timing_r;
    logic [31:0] wmap_r;
    logic [31:0] rmap_r;
    bg_cmd_t     cmd_q [$];             // one entry per cycle, idle entries included
    odt_phases_t exp_tl [TL_LEN];       // expected afi_odt per cycle of a run

    odt_subsys_top odt_subsys_top_i (
        .ctl_clk    (ctl_clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .bg_cmd     (bg_cmd),
        .afi_odt    (afi_odt)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    task automatic check_phases(input string name, input odt_phases_t exp, input odt_phases_t act);
        checks++;
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_axil_data(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp)
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // aw and w together, then wait for b
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(posedge ctl_clk);
        #DRV_DLY;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        n = 0;
        @(negedge ctl_clk);
        while (!axil_rsp.awready && n < POLL_MAX)
        begin
            @(negedge ctl_clk);
            n++;
        end
        if (n >= POLL_MAX)
        begin
            $display("** Error at %0t ns: write address and data were never accepted", $time);
            errors++;
        end
        else if (axil_rsp.wready !== 1'b1)
        begin
            // w is taken in the same cycle as aw
            $display("** Error at %0t ns: wready expected 1, got %b", $time, axil_rsp.wready);
            errors++;
        end
        @(posedge ctl_clk);
        #DRV_DLY;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        @(negedge ctl_clk);
        while (!axil_rsp.bvalid && n < POLL_MAX)
        begin
            @(negedge ctl_clk);
            n++;
        end
        if (n >= POLL_MAX)
        begin
            $display("** Error at %0t ns: no write response came back", $time);
            errors++;
        end
        resp = axil_rsp.bresp;
        @(posedge ctl_clk);             // b handshake on this edge
        #DRV_DLY;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge ctl_clk);
        #DRV_DLY;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        n = 0;
        @(negedge ctl_clk);
        while (!axil_rsp.arready && n < POLL_MAX)
        begin
            @(negedge ctl_clk);
            n++;
        end
        if (n >= POLL_MAX)
        begin
            $display("** Error at %0t ns: read address was never accepted", $time);
            errors++;
        end
        @(posedge ctl_clk);
        #DRV_DLY;
        axil_req.arvalid = 1'b0;
        n = 0;
        @(negedge ctl_clk);
        while (!axil_rsp.rvalid && n < POLL_MAX)
        begin
            @(negedge ctl_clk);
            n++;
        end
        if (n >= POLL_MAX)
        begin
            $display("** Error at %0t ns: no read data came back", $time);
            errors++;
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge ctl_clk);
        #DRV_DLY;
        axil_req.rready = 1'b0;
    endtask

    // full word write, keeps the software copy in step
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, 4'hf, resp);
        check_resp("bresp", OKAY, resp);
        case (addr)
            `ODT_REG_CTRL:   ctrl_r   = data;
            `ODT_REG_TIMING: timing_r = data;
            `ODT_REG_WMAP:   wmap_r   = data;
            `ODT_REG_RMAP:   rmap_r   = data;
            default:         ctrl_r   = ctrl_r;
        endcase
    endtask

    function automatic logic [31:0] pack_timing(input logic [3:0] tcl, input logic [3:0] cwl,
                                                input logic [2:0] al, input logic [4:0] bl);
        return {11'd0, bl, 5'd0, al, cwl, tcl};
    endfunction

    function automatic bg_cmd_t mk_cmd(input logic rd, input logic wr, input logic bc,
                                       input logic [3:0] chips);
        bg_cmd_t c;
        c.do_read    = rd;
        c.do_write   = wr;
        c.burst_chop = bc;
        c.to_chip    = chips;
        return c;
    endfunction

    task automatic push_cmd(input bg_cmd_t c, input int gap);
        cmd_q.push_back(c);
        repeat (gap) cmd_q.push_back(mk_cmd(1'b0, 1'b0, 1'b0, 4'h0));
    endtask

    // slot s of a command in cycle k lands in cycle k+1+regd+s/2, even slots on phase l
    task automatic add_window(input int k, input logic [3:0] pins, input int start,
                              input int len, input int regd);
        int cyc;
        for (int s = start; s < start + len; s++)
        begin
            cyc = k + 1 + regd + s / 2;
            if (cyc < TL_LEN)
            begin
                if (s % 2 == 0)
                    exp_tl[cyc].l = exp_tl[cyc].l | pins;
                else
                    exp_tl[cyc].h = exp_tl[cyc].h | pins;
            end
        end
    endtask

    // reference model of the odt window rule, works from the software copies
    task automatic model_cmd(input int k, input bg_cmd_t c);
        int chip;
        int mt;
        int regd;
        int tcl;
        int cwl;
        int al;
        int bl;
        int len;
        logic [3:0] pw;
        logic [3:0] pr;
        chip = -1;
        for (int i = 0; i < 4; i++)
        begin
            if (c.to_chip[i])
                chip = i;               // highest chip wins
        end
        if (chip < 0 || `ODT_ENABLED == 0)
            return;
        mt   = int'(ctrl_r[2:0]);
        regd = int'(ctrl_r[4]);
        tcl  = int'(timing_r[3:0]);
        cwl  = int'(timing_r[7:4]);
        al   = int'(timing_r[10:8]);
        bl   = int'(timing_r[20:16]);
        pw   = c.do_write ? wmap_r[chip*4 +: 4] : 4'h0;
        pr   = c.do_read ? rmap_r[chip*4 +: 4] : 4'h0;
        if (mt == 1)
            add_window(k, pw | pr, tcl + al - 2, bl / 2 + 2, regd);   // ddr2
        else if (mt == 2)
        begin
            len = c.burst_chop ? 4 : bl / 2 + 2;
            add_window(k, pw, cwl - 2, len, regd);
            add_window(k, pr, tcl - 2, len, regd);
        end
    endtask

    // plays the queued commands one per cycle and checks afi_odt every cycle
    task automatic run_cmds();
        int n;
        for (int i = 0; i < TL_LEN; i++)
            exp_tl[i] = '0;
        for (int k = 0; k < cmd_q.size(); k++)
            model_cmd(k, cmd_q[k]);
        n = cmd_q.size() + FLUSH;
        for (int k = 0; k < n; k++)
        begin
            @(posedge ctl_clk);
            #DRV_DLY;
            if (k < cmd_q.size())
                bg_cmd = cmd_q[k];
            else
                bg_cmd = '0;
            @(negedge ctl_clk);         // mid cycle, outputs settled
            check_phases("afi_odt", exp_tl[k], afi_odt);
        end
        cmd_q.delete();
    endtask

    task automatic chip_sweep(input logic bc, input int gap);
        for (int i = 0; i < 4; i++)
        begin
            push_cmd(mk_cmd(1'b0, 1'b1, bc, 4'(1 << i)), gap);
            push_cmd(mk_cmd(1'b1, 1'b0, bc, 4'(1 << i)), gap);
        end
    endtask

    task automatic test_reset_regs();
        logic [31:0] d;
        logic [1:0]  r;
        int          e0;
        e0 = errors;
        for (int a = 0; a < 16; a += 4)
        begin
            axil_read(4'(a), d, r);
            check_axil_data("rdata", 32'h0, d);
            check_resp("rresp", OKAY, r);
        end
        chip_sweep(1'b0, 3);            // mem type none, afi_odt stays low
        push_cmd(mk_cmd(1'b1, 1'b1, 1'b0, 4'hf), 3);
        run_cmds();
        write_reg(`ODT_REG_CTRL, 32'h5a5a_0013);
        write_reg(`ODT_REG_TIMING, 32'h0013_0a5c);
        write_reg(`ODT_REG_WMAP, 32'hc0de_a521);
        write_reg(`ODT_REG_RMAP, 32'h1234_c384);
        axil_read(`ODT_REG_CTRL, d, r);
        check_axil_data("rdata ctrl", 32'h5a5a_0013, d);
        axil_read(`ODT_REG_TIMING, d, r);
        check_axil_data("rdata timing", 32'h0013_0a5c, d);
        axil_read(`ODT_REG_WMAP, d, r);
        check_axil_data("rdata wmap", 32'hc0de_a521, d);
        axil_read(`ODT_REG_RMAP, d, r);
        check_axil_data("rdata rmap", 32'h1234_c384, d);
        check_resp("rresp", OKAY, r);
        axil_write(`ODT_REG_WMAP, 32'hffff_ffff, 4'b0100, r);   // byte 2 only
        check_resp("bresp", OKAY, r);
        axil_read(`ODT_REG_WMAP, d, r);
        check_axil_data("rdata wmap", 32'hc0ff_a521, d);
        axil_write(4'h6, 32'hffff_ffff, 4'hf, r);
        check_resp("bresp", SLVERR, r);
        axil_read(4'h6, d, r);
        check_axil_data("rdata", 32'h0, d);
        check_resp("rresp", SLVERR, r);
        for (int a = 0; a < 16; a += 4)
            write_reg(4'(a), 32'h0);
        $display("test reset and registers done, %0d errors", errors - e0);
    endtask

    task automatic test_ddr2();
        int e0;
        e0 = errors;
        write_reg(`ODT_REG_WMAP, 32'h0000_a521);
        write_reg(`ODT_REG_RMAP, 32'h0000_c384);
        write_reg(`ODT_REG_TIMING, pack_timing(4'd5, 4'd4, 3'd0, 5'd8));   // odd start
        write_reg(`ODT_REG_CTRL, 32'h1);
        chip_sweep(1'b0, 12);
        run_cmds();
        write_reg(`ODT_REG_TIMING, pack_timing(4'd5, 4'd4, 3'd1, 5'd8));   // even start
        chip_sweep(1'b0, 12);
        run_cmds();
        $display("test ddr2 windows done, %0d errors", errors - e0);
    endtask

    task automatic test_ddr3();
        int e0;
        e0 = errors;
        write_reg(`ODT_REG_TIMING, pack_timing(4'd6, 4'd5, 3'd0, 5'd8));
        write_reg(`ODT_REG_CTRL, 32'h2);
        chip_sweep(1'b0, 12);
        chip_sweep(1'b1, 12);           // bc4
        run_cmds();
        $display("test ddr3 windows done, %0d errors", errors - e0);
    endtask

    task automatic test_overlap();
        int          e0;
        logic [31:0] rnd;
        e0 = errors;
        push_cmd(mk_cmd(1'b0, 1'b1, 1'b0, 4'b0001), 0);
        push_cmd(mk_cmd(1'b0, 1'b1, 1'b1, 4'b0010), 0);
        push_cmd(mk_cmd(1'b1, 1'b0, 1'b0, 4'b0100), 0);
        push_cmd(mk_cmd(1'b0, 1'b1, 1'b0, 4'b1000), 12);
        push_cmd(mk_cmd(1'b0, 1'b1, 1'b0, 4'b0110), 12);   // chip 2 map
        push_cmd(mk_cmd(1'b1, 1'b0, 1'b0, 4'b1111), 12);
        push_cmd(mk_cmd(1'b1, 1'b1, 1'b0, 4'b0000), 12);   // no chip
        run_cmds();
        write_reg(`ODT_REG_TIMING, pack_timing(4'd4, 4'd3, 3'd1, 5'd6));
        write_reg(`ODT_REG_CTRL, 32'h1);
        for (int i = 0; i < 40; i++)
        begin
            rnd = $random(seed);
            push_cmd(mk_cmd(rnd[0], rnd[1], rnd[2], rnd[7:4]), 0);
        end
        run_cmds();
        $display("test overlap and chip select done, %0d errors", errors - e0);
    endtask

    task automatic test_regd_none();
        int e0;
        e0 = errors;
        write_reg(`ODT_REG_TIMING, pack_timing(4'd5, 4'd4, 3'd0, 5'd8));
        write_reg(`ODT_REG_CTRL, 32'h11);  // ddr2 with output_regd
        chip_sweep(1'b0, 6);
        run_cmds();
        write_reg(`ODT_REG_CTRL, 32'h12);  // ddr3 with output_regd
        chip_sweep(1'b1, 6);
        run_cmds();
        write_reg(`ODT_REG_CTRL, 32'h0);
        chip_sweep(1'b0, 2);
        run_cmds();
        $display("test output_regd and mem type none done, %0d errors", errors - e0);
    endtask

    initial
    begin
        seed     = 32'ha276bace;
        errors   = 0;
        checks   = 0;
        rst_n    = 1'b0;
        axil_req = '0;
        bg_cmd   = '0;
        ctrl_r   = '0;
        timing_r = '0;
        wmap_r   = '0;
        rmap_r   = '0;
        repeat (8) @(posedge ctl_clk);
        #DRV_DLY;
        rst_n = 1'b1;
        test_reset_regs();
        test_ddr2();
        test_ddr3();
        test_overlap();
        test_regd_none();
        $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // 400 cycles per test in total
    initial
    begin
        #(N_TESTS * 400 * CLK_PERIOD);
        $display("** Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
odt_pkg.sv
odt_csr.sv
odt_ddr2_gen.sv
odt_ddr3_gen.sv
odt_gen.sv
odt_subsys_top.sv
tb_odt_subsys.sv

// ==== Makefile ====
# verilator build and run of the odt subsystem testbench

TOP = tb_odt_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
